/* design/bridge_pkg.sv */
// host bridge definitions
// bridge request struct, decoded settings struct
// settings register address map and save window nibble

`default_nettype none

package bridge_pkg;

  ////////////////////////////////////////
  // bridge cycle

  typedef struct packed {
    logic [31:0] addr;
    logic        wr;
    logic [31:0] wr_data;
    logic        rd;
  } bridge_req_t;

  ////////////////////////////////////////
  // decoded settings

  typedef struct packed {
    logic       cpu_turbo;
    logic       gsu_turbo;
    logic       multitap;
    logic       lightgun_en;
    logic       lightgun_type;
    logic       use_4_3_video;
    logic       blend;
    logic [7:0] lightgun_aim_speed;
    logic [3:0] rom_size;
    logic [3:0] ram_size;
  } settings_t;

  ////////////////////////////////////////
  // address map

  localparam logic [31:0] reg_rom_size_addr  = 32'h0000_0004;
  localparam logic [31:0] reg_ram_size_addr  = 32'h0000_000C;
  localparam logic [31:0] reg_reset_addr     = 32'h0000_0050;
  localparam logic [31:0] reg_cpu_turbo_addr = 32'h0000_0080;
  localparam logic [31:0] reg_gsu_turbo_addr = 32'h0000_0084;
  localparam logic [31:0] reg_multitap_addr  = 32'h0000_0100;
  localparam logic [31:0] reg_lightgun_addr  = 32'h0000_0104;
  localparam logic [31:0] reg_aim_speed_addr = 32'h0000_0108;
  localparam logic [31:0] reg_video_43_addr  = 32'h0000_0200;
  localparam logic [31:0] reg_blend_addr     = 32'h0000_0204;

  // top four address bits select the save window
  localparam logic [3:0] save_region_nibble = 4'h2;

endpackage

`default_nettype wire

/* design/core_pkg.sv */
// types shared with the core side
// packed clock word, data-table write, video in and out
// data-table and video slot word constants

`default_nettype none

package core_pkg;

  // clock word as the core expects it
  typedef struct packed {
    logic       changed;
    logic [7:0] empty;
    logic [7:0] weekday;
    logic [7:0] year;
    logic [7:0] month;
    logic [7:0] day;
    logic [7:0] hour;
    logic [7:0] minute;
    logic [7:0] second;
  } rtc_t;

  typedef struct packed {
    logic        wren;
    logic [9:0]  addr;
    logic [31:0] data;
  } datatable_t;

  typedef struct packed {
    logic        hs;
    logic        vs;
    logic        de;
    logic [23:0] rgb;
    logic [7:0]  snap_index;
  } video_in_t;

  typedef struct packed {
    logic        de;
    logic [23:0] rgb;
  } video_out_t;

  // data slot 1 sits at table entry 1 * 2 + 1
  localparam logic [9:0]  save_slot_table_addr = 10'd3;
  localparam logic [31:0] save_size_unit       = 32'd1024;

  // flag positions in the end-of-line control word
  localparam int slot_word_ratio_bit = 14;
  localparam int slot_word_43_bit    = 13;

endpackage

`default_nettype wire

/* design/bridge_settings_regs.sv */
// settings register file on the host bridge
// address decode into the settings struct
// core reset pulse from a down-counter

`timescale 1ns/1ps
`default_nettype none

module bridge_settings_regs #(
  parameter int RESET_HOLD_CYCLES = 16
) (
  input  wire                             clk_74a,
  input  wire                             pll_core_locked,
  input  wire bridge_pkg::bridge_req_t    bridge,
  output bridge_pkg::settings_t           settings,
  output logic                            core_reset
);

  localparam int CNT_W = $clog2(RESET_HOLD_CYCLES + 1);

  logic [CNT_W-1:0] reset_count;

  ////////////////////////////////////////
  // settings decode

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings <= '0;
    end else if (bridge.wr) begin
      case (bridge.addr)
        bridge_pkg::reg_rom_size_addr: begin
          settings.rom_size <= bridge.wr_data[3:0];
        end
        bridge_pkg::reg_ram_size_addr: begin
          settings.ram_size <= bridge.wr_data[3:0];
        end
        bridge_pkg::reg_cpu_turbo_addr: begin
          settings.cpu_turbo <= bridge.wr_data[0];
        end
        bridge_pkg::reg_gsu_turbo_addr: begin
          settings.gsu_turbo <= bridge.wr_data[0];
        end
        bridge_pkg::reg_multitap_addr: begin
          settings.multitap <= bridge.wr_data[0];
        end
        bridge_pkg::reg_lightgun_addr: begin
          // enable and gun type share one word
          settings.lightgun_en   <= bridge.wr_data[0];
          settings.lightgun_type <= bridge.wr_data[1];
        end
        bridge_pkg::reg_aim_speed_addr: begin
          settings.lightgun_aim_speed <= bridge.wr_data[7:0];
        end
        bridge_pkg::reg_video_43_addr: begin
          settings.use_4_3_video <= bridge.wr_data[0];
        end
        bridge_pkg::reg_blend_addr: begin
          settings.blend <= bridge.wr_data[0];
        end
        default: begin
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // reset pulse

  // any write to the reset register restarts the hold time
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      reset_count <= '0;
    end else if (bridge.wr && bridge.addr == bridge_pkg::reg_reset_addr) begin
      reset_count <= CNT_W'(RESET_HOLD_CYCLES);
    end else if (reset_count != '0) begin
      reset_count <= reset_count - CNT_W'(1);
    end
  end

  assign core_reset = (reset_count != '0);

endmodule

`default_nettype wire

/* design/save_ram_port.sv */
// save-data window on the host bridge
// word RAM written and read through the top address nibble
// registered read data with one cycle of latency

`timescale 1ns/1ps
`default_nettype none

module save_ram_port #(
  parameter int SAVE_ADDR_BITS = 6
) (
  input  wire                          clk_74a,
  input  wire                          pll_core_locked,
  input  wire bridge_pkg::bridge_req_t bridge,
  output logic [31:0]                  bridge_rd_data
);

  localparam int SAVE_WORDS = 2 ** SAVE_ADDR_BITS;

  logic [31:0]               save_mem [SAVE_WORDS];
  logic [SAVE_ADDR_BITS-1:0] word_index;
  logic                      in_window;

  // word addressed, byte lanes are not split
  assign word_index = bridge.addr[SAVE_ADDR_BITS+1:2];
  assign in_window  = (bridge.addr[31:28] == bridge_pkg::save_region_nibble);

  ////////////////////////////////////////
  // storage

  always_ff @(posedge clk_74a) begin
    if (bridge.wr && in_window) begin
      save_mem[word_index] <= bridge.wr_data;
    end
  end

  ////////////////////////////////////////
  // read path

  // holds the last read until the next one
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      bridge_rd_data <= '0;
    end else if (bridge.rd) begin
      if (in_window) begin
        bridge_rd_data <= save_mem[word_index];
      end else begin
        bridge_rd_data <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* design/dataslot_monitor.sv */
// data-slot bookkeeping
// save activity flag from requests and allcomplete
// data-table write reporting the save size in bytes

`timescale 1ns/1ps
`default_nettype none

module dataslot_monitor (
  input  wire                  clk_74a,
  input  wire                  pll_core_locked,
  input  wire                  dataslot_requestread,
  input  wire                  dataslot_requestwrite,
  input  wire                  dataslot_allcomplete,
  input  wire [3:0]            sram_size,
  output logic                 save_active,
  output core_pkg::datatable_t datatable
);

  logic allcomplete_prev;

  // request wins over a completion in the same cycle
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      allcomplete_prev <= 1'b0;
      save_active      <= 1'b0;
    end else begin
      allcomplete_prev <= dataslot_allcomplete;
      if (dataslot_requestread || dataslot_requestwrite) begin
        save_active <= 1'b1;
      end else if (dataslot_allcomplete && !allcomplete_prev) begin
        save_active <= 1'b0;
      end
    end
  end

  // sram_size is a power-of-two code, 0 means no save ram
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      datatable <= '0;
    end else begin
      datatable.wren <= 1'b1;
      datatable.addr <= core_pkg::save_slot_table_addr;
      datatable.data <= (sram_size != 4'd0) ? (core_pkg::save_size_unit << sram_size) : '0;
    end
  end

endmodule

`default_nettype wire

/* design/rtc_packer.sv */
// host clock packing
// change toggle on a new time value
// date and time bytes into the core clock word

`timescale 1ns/1ps
`default_nettype none

module rtc_packer (
  input  wire            clk_74a,
  input  wire            pll_core_locked,
  input  wire [31:0]     rtc_date,
  input  wire [31:0]     rtc_time,
  output core_pkg::rtc_t rtc
);

  logic [31:0] prev_time;
  logic        changed;

  // core watches for the toggle, not a level
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      prev_time <= '0;
      changed   <= 1'b0;
    end else if (rtc_time != prev_time) begin
      prev_time <= rtc_time;
      changed   <= ~changed;
    end
  end

  // weekday is not supplied by the host
  assign rtc.changed = changed;
  assign rtc.empty   = 8'h00;
  assign rtc.weekday = 8'h01;
  assign rtc.year    = rtc_date[23:16];
  assign rtc.month   = rtc_date[15:8];
  assign rtc.day     = rtc_date[7:0];
  assign rtc.hour    = rtc_time[23:16];
  assign rtc.minute  = rtc_time[15:8];
  assign rtc.second  = rtc_time[7:0];

endmodule

`default_nettype wire

/* design/video_slot_inserter.sv */
// end-of-line video control word
// snap index latch on vsync rise
// active pixel pass-through with one cycle of latency

`timescale 1ns/1ps
`default_nettype none

module video_slot_inserter (
  input  wire                 clk_74a,
  input  wire                 pll_core_locked,
  input  wire core_pkg::video_in_t video_in,
  input  wire                 use_4_3_video,
  output core_pkg::video_out_t video_out
);

  logic        prev_de;
  logic        prev_vs;
  logic        latched_snap;
  logic [23:0] slot_word;

  // scaler slot word with aspect select and 4:3 flag
  always_comb begin
    slot_word = '0;
    slot_word[core_pkg::slot_word_ratio_bit] = ~latched_snap;
    slot_word[core_pkg::slot_word_43_bit]    = use_4_3_video;
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      prev_de       <= 1'b0;
      prev_vs       <= 1'b0;
      latched_snap  <= 1'b0;
      video_out     <= '0;
    end else begin
      prev_de      <= video_in.de;
      prev_vs      <= video_in.vs;
      video_out.de <= 1'b0;

      // only bit 0 of the snap index selects the aspect
      if (video_in.vs && !prev_vs) begin
        latched_snap <= video_in.snap_index[0];
      end

      // first blank pixel of the line carries the slot word
      if (!video_in.de && prev_de) begin
        video_out.rgb <= slot_word;
      end else if (video_in.de) begin
        video_out.de  <= 1'b1;
        video_out.rgb <= video_in.rgb;
      end
    end
  end

endmodule

`default_nettype wire

/* design/pocket_core_top.sv */
// host-side glue top level
// bridge request packing, settings, save window,
// data-slot tracking, clock packing and video slot word

`timescale 1ns/1ps
`default_nettype none

module pocket_core_top #(
  parameter int RESET_HOLD_CYCLES = 16,
  parameter int SAVE_ADDR_BITS    = 6
) (
  input  wire                     clk_74a,
  input  wire                     pll_core_locked,

  // host bridge
  input  wire [31:0]              bridge_addr,
  input  wire                     bridge_wr,
  input  wire [31:0]              bridge_wr_data,
  input  wire                     bridge_rd,
  output logic [31:0]             bridge_rd_data,
  output logic                    bridge_endian_little,

  // data slots and clock
  input  wire                     dataslot_requestread,
  input  wire                     dataslot_requestwrite,
  input  wire                     dataslot_allcomplete,
  input  wire [3:0]               sram_size,
  input  wire [31:0]              rtc_date,
  input  wire [31:0]              rtc_time,

  // video
  input  wire core_pkg::video_in_t video_in,

  output bridge_pkg::settings_t   settings,
  output logic                    core_reset,
  output logic                    save_active,
  output core_pkg::datatable_t    datatable,
  output core_pkg::rtc_t          rtc,
  output core_pkg::video_out_t    video_out
);

  bridge_pkg::bridge_req_t bridge_req;

  // one request bundle shared by every bridge device
  assign bridge_req = '{
    addr:    bridge_addr,
    wr:      bridge_wr,
    wr_data: bridge_wr_data,
    rd:      bridge_rd
  };

  // big endian bridge
  assign bridge_endian_little = 1'b0;

  ////////////////////////////////////////
  // bridge devices

  bridge_settings_regs #(
    .RESET_HOLD_CYCLES(RESET_HOLD_CYCLES)
  ) i_bridge_settings_regs (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge          (bridge_req),
    .settings        (settings),
    .core_reset      (core_reset)
  );

  save_ram_port #(
    .SAVE_ADDR_BITS(SAVE_ADDR_BITS)
  ) i_save_ram_port (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge          (bridge_req),
    .bridge_rd_data  (bridge_rd_data)
  );

  ////////////////////////////////////////
  // core side helpers

  dataslot_monitor i_dataslot_monitor (
    .clk_74a               (clk_74a),
    .pll_core_locked       (pll_core_locked),
    .dataslot_requestread  (dataslot_requestread),
    .dataslot_requestwrite (dataslot_requestwrite),
    .dataslot_allcomplete  (dataslot_allcomplete),
    .sram_size             (sram_size),
    .save_active           (save_active),
    .datatable             (datatable)
  );

  rtc_packer i_rtc_packer (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .rtc_date        (rtc_date),
    .rtc_time        (rtc_time),
    .rtc             (rtc)
  );

  video_slot_inserter i_video_slot_inserter (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .video_in        (video_in),
    .use_4_3_video   (settings.use_4_3_video),
    .video_out       (video_out)
  );

endmodule

`default_nettype wire

/* test/pocket_core_tests.svh */
// directed tests for the host-side glue
// bridge write and read helpers
// settings, reset pulse, save window, data slots, clock, video

  ////////////////////////////////////////
  // bridge access

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_74a);
    bridge_addr    <= addr;
    bridge_wr_data <= data;
    bridge_wr      <= 1'b1;
    @(posedge clk_74a);
    bridge_wr <= 1'b0;
  endtask

  task automatic write_random(input logic [31:0] addr, output logic [31:0] data);
    data = random_bits(32);
    bus_write(addr, data);
  endtask

  // returns once the registered read data has settled
  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge clk_74a);
    bridge_addr <= addr;
    bridge_rd   <= 1'b1;
    @(posedge clk_74a);
    bridge_rd <= 1'b0;
    @(negedge clk_74a);
    data = bridge_rd_data;
  endtask

  ////////////////////////////////////////
  // tests

  task automatic test_settings_decode();
    bridge_pkg::settings_t expected;
    logic [31:0]           data;
    int                    errors_before;
    errors_before = errors;
    expected      = '0;
    write_random(bridge_pkg::reg_rom_size_addr, data);
    expected.rom_size = data[3:0];
    write_random(bridge_pkg::reg_ram_size_addr, data);
    expected.ram_size = data[3:0];
    write_random(bridge_pkg::reg_cpu_turbo_addr, data);
    expected.cpu_turbo = data[0];
    write_random(bridge_pkg::reg_gsu_turbo_addr, data);
    expected.gsu_turbo = data[0];
    write_random(bridge_pkg::reg_multitap_addr, data);
    expected.multitap = data[0];
    // enable in bit 0, gun type in bit 1
    write_random(bridge_pkg::reg_lightgun_addr, data);
    expected.lightgun_en   = data[0];
    expected.lightgun_type = data[1];
    write_random(bridge_pkg::reg_aim_speed_addr, data);
    expected.lightgun_aim_speed = data[7:0];
    write_random(bridge_pkg::reg_video_43_addr, data);
    expected.use_4_3_video = data[0];
    write_random(bridge_pkg::reg_blend_addr, data);
    expected.blend = data[0];
    @(negedge clk_74a);
    check_settings("settings", settings, expected);
    write_random(32'h0000_0008, data);
    @(negedge clk_74a);
    check_settings("settings", settings, expected);
    finish_test("settings decode", errors_before);
  endtask

  task automatic test_reset_pulse();
    int errors_before;
    errors_before = errors;
    bus_write(bridge_pkg::reg_reset_addr, 32'h1);
    repeat (reset_hold_cycles) begin
      @(negedge clk_74a);
      check_bit("core_reset", core_reset, 1'b1);
    end
    @(negedge clk_74a);
    check_bit("core_reset", core_reset, 1'b0);
    finish_test("reset pulse", errors_before);
  endtask

  task automatic test_save_window();
    logic [31:0] addrs [4];
    logic [31:0] data [4];
    logic [31:0] readback;
    int          errors_before;
    int          i;
    errors_before = errors;
    addrs = '{32'h2000_0000, 32'h2000_0004, 32'h2000_0058, 32'h2000_00FC};
    for (i = 0; i < 4; i++) begin
      write_random(addrs[i], data[i]);
    end
    // all words written first so aliased indexes show up
    for (i = 0; i < 4; i++) begin
      bus_read(addrs[i], readback);
      check_word("bridge_rd_data", readback, data[i]);
    end
    // outside the window
    bus_read(32'h1000_0000, readback);
    check_word("bridge_rd_data", readback, 32'h0);
    check_bit("bridge_endian_little", bridge_endian_little, 1'b0);
    finish_test("save window", errors_before);
  endtask

  task automatic test_data_slots();
    core_pkg::datatable_t expected;
    logic [3:0]           sizes [3];
    logic [31:0]          size_bytes [3];
    int                   errors_before;
    int                   i;
    errors_before = errors;
    @(posedge clk_74a);
    dataslot_requestread <= 1'b1;
    @(posedge clk_74a);
    dataslot_requestread <= 1'b0;
    dataslot_allcomplete <= 1'b1;
    @(negedge clk_74a);
    check_bit("save_active", save_active, 1'b1);
    @(negedge clk_74a);
    check_bit("save_active", save_active, 1'b0);
    // allcomplete stays high, so a new request is not cleared
    @(posedge clk_74a);
    dataslot_requestwrite <= 1'b1;
    @(posedge clk_74a);
    dataslot_requestwrite <= 1'b0;
    repeat (3) begin
      @(negedge clk_74a);
      check_bit("save_active", save_active, 1'b1);
    end
    @(posedge clk_74a);
    dataslot_allcomplete <= 1'b0;
    @(posedge clk_74a);
    dataslot_allcomplete <= 1'b1;
    @(posedge clk_74a);
    @(negedge clk_74a);
    check_bit("save_active", save_active, 1'b0);
    sizes      = '{4'd0, 4'd1, 4'd3};
    size_bytes = '{32'd0, 32'd2048, 32'd8192};
    for (i = 0; i < 3; i++) begin
      @(posedge clk_74a);
      sram_size <= sizes[i];
      @(posedge clk_74a);
      @(negedge clk_74a);
      expected = '{wren: 1'b1, addr: 10'd3, data: size_bytes[i]};
      check_datatable("datatable", datatable, expected);
    end
    finish_test("data slots", errors_before);
  endtask

  task automatic test_rtc_packing();
    core_pkg::rtc_t expected;
    int             errors_before;
    errors_before = errors;
    expected = '{changed: 1'b0, empty: 8'h00, weekday: 8'h01, year: 8'h5A, month: 8'h0B,
                 day: 8'h1C, hour: 8'h17, minute: 8'h2A, second: 8'h3B};
    @(posedge clk_74a);
    rtc_date <= 32'h7E5A_0B1C;
    rtc_time <= 32'hC317_2A3B;
    // fields follow at once, toggle waits for the edge
    @(negedge clk_74a);
    check_rtc("rtc", rtc, expected);
    expected.changed = 1'b1;
    repeat (4) begin
      @(negedge clk_74a);
      check_rtc("rtc", rtc, expected);
    end
    @(posedge clk_74a);
    rtc_time <= 32'hC317_2A3C;
    @(posedge clk_74a);
    @(negedge clk_74a);
    expected.changed = 1'b0;
    expected.second  = 8'h3C;
    check_rtc("rtc", rtc, expected);
    finish_test("clock packing", errors_before);
  endtask

  task automatic test_video_slot();
    core_pkg::video_out_t expected;
    logic [31:0]          pixels [3];
    int                   errors_before;
    int                   i;
    errors_before = errors;
    bus_write(bridge_pkg::reg_video_43_addr, 32'h1);
    for (i = 0; i < 3; i++) begin
      pixels[i] = random_bits(24);
    end
    @(posedge clk_74a);
    video_in.vs         <= 1'b1;
    video_in.snap_index <= 8'h00;
    @(posedge clk_74a);
    video_in.vs  <= 1'b0;
    video_in.de  <= 1'b1;
    video_in.rgb <= pixels[0][23:0];
    // a later index is ignored until the next vsync rise
    video_in.snap_index <= 8'h01;
    for (i = 0; i < 3; i++) begin
      @(posedge clk_74a);
      if (i < 2) begin
        video_in.rgb <= pixels[i + 1][23:0];
      end else begin
        video_in.de  <= 1'b0;
        video_in.rgb <= 24'h0;
      end
      @(negedge clk_74a);
      expected = '{de: 1'b1, rgb: pixels[i][23:0]};
      check_video("video_out", video_out, expected);
    end
    // bit 14 for snap index 0, bit 13 for 4:3
    expected = '{de: 1'b0, rgb: 24'h006000};
    repeat (2) begin
      @(negedge clk_74a);
      check_video("video_out", video_out, expected);
    end
    finish_test("video slot", errors_before);
  endtask

/* test/tb_pocket_core.sv */
// testbench for the host-side glue top level
// clock, reset, DUT instance, LFSR stimulus source
// compare tasks, watchdog and closing summary

`timescale 1ns/1ps
`default_nettype none

module tb_pocket_core;

  localparam int num_tests         = 6;
  localparam int reset_hold_cycles = 16;

  logic                  clk_74a;
  logic                  pll_core_locked;
  logic [31:0]           bridge_addr;
  logic                  bridge_wr;
  logic [31:0]           bridge_wr_data;
  logic                  bridge_rd;
  logic [31:0]           bridge_rd_data;
  logic                  bridge_endian_little;
  logic                  dataslot_requestread;
  logic                  dataslot_requestwrite;
  logic                  dataslot_allcomplete;
  logic [3:0]            sram_size;
  logic [31:0]           rtc_date;
  logic [31:0]           rtc_time;
  core_pkg::video_in_t   video_in;
  bridge_pkg::settings_t settings;
  logic                  core_reset;
  logic                  save_active;
  core_pkg::datatable_t  datatable;
  core_pkg::rtc_t        rtc;
  core_pkg::video_out_t  video_out;

  int          checks     = 0;
  int          errors     = 0;
  int          tests_run  = 0;
  logic [31:0] lfsr_state = 32'h560a;

  pocket_core_top i_pocket_core_top (.*);

  initial begin
    clk_74a = 1'b0;
    forever #5 clk_74a = ~clk_74a;
  end

  ////////////////////////////////////////
  // stimulus source

  // fibonacci form, taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    int          i;
    value = '0;
    for (i = 0; i < count; i++) begin
      value = {value[30:0], lfsr_bit()};
    end
    return value;
  endfunction

  ////////////////////////////////////////
  // compare tasks

  task automatic check_settings(input string name, input bridge_pkg::settings_t got,
                                input bridge_pkg::settings_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_rtc(input string name, input core_pkg::rtc_t got,
                           input core_pkg::rtc_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_datatable(input string name, input core_pkg::datatable_t got,
                                 input core_pkg::datatable_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_video(input string name, input core_pkg::video_out_t got,
                             input core_pkg::video_out_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d mismatches", name, errors - errors_before);
    end
  endtask

  `include "pocket_core_tests.svh"

  ////////////////////////////////////////
  // run control

  initial begin
    #(num_tests * 2000);
    $display("watchdog expired after %0d ns before the tests completed", num_tests * 2000);
    $display("tests failed");
    $finish;
  end

  initial begin
    pll_core_locked       <= 1'b0;
    bridge_addr           <= '0;
    bridge_wr             <= 1'b0;
    bridge_wr_data        <= '0;
    bridge_rd             <= 1'b0;
    dataslot_requestread  <= 1'b0;
    dataslot_requestwrite <= 1'b0;
    dataslot_allcomplete  <= 1'b0;
    sram_size             <= '0;
    rtc_date              <= '0;
    rtc_time              <= '0;
    video_in              <= '0;
    repeat (8) @(posedge clk_74a);
    pll_core_locked <= 1'b1;
    @(posedge clk_74a);
    test_settings_decode();
    test_reset_pulse();
    test_save_window();
    test_data_slots();
    test_rtc_packing();
    test_video_slot();
    $display("summary: %0d tests, %0d checks, %0d mismatches", tests_run, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+test
design/bridge_pkg.sv
design/core_pkg.sv
design/bridge_settings_regs.sv
design/save_ram_port.sv
design/dataslot_monitor.sv
design/rtc_packer.sv
design/video_slot_inserter.sv
design/pocket_core_top.sv
test/tb_pocket_core.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator and run it
set -e

verilator --binary --timing -j 0 --top-module tb_pocket_core -f sources.f -Mdir obj_dir

sim_output=$(./obj_dir/Vtb_pocket_core)
echo "$sim_output"

if echo "$sim_output" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1
